// File: common/attn_consts.svh
`ifndef ATTN_CONSTS_SVH
`define ATTN_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tensor shape of one attention head
`define ATTN_W          32
`define ATTN_M1         2
`define ATTN_M2         2
`define ATTN_M3         2
`define ATTN_HEADS      2
`define ATTN_KEEP_A     2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store layout, input groups first and then one block per head
`define ATTN_ADDR_W     7
`define ATTN_HEAD_WORDS (3 * (`ATTN_M2 * `ATTN_M3 + 3 * `ATTN_M3) + 2)
`define ATTN_HEAD_BASE  (`ATTN_M1 * `ATTN_M2 * (`ATTN_HEADS / `ATTN_KEEP_A))

`define ATTN_WB_ADR_W   8
`define ATTN_CNT_W      3

`endif

// File: common/seg_pkg.sv
`include "attn_consts.svh"

package seg_pkg;

    // stream order of the segments.
    typedef enum logic [3:0] {
        seg_i,
        seg_w_q, seg_bias_q, seg_m_q, seg_e_q,
        seg_w_k, seg_bias_k, seg_m_k, seg_e_k,
        seg_w_v, seg_bias_v, seg_m_v, seg_e_v,
        seg_m_c,
        seg_e_c
    } seg_t;

    typedef logic [`ATTN_ADDR_W-1:0] seg_addr_t;

    function automatic seg_addr_t seg_len(input seg_t kind);
        case (kind)
            seg_i:                     return seg_addr_t'(`ATTN_M1 * `ATTN_M2);
            seg_w_q, seg_w_k, seg_w_v: return seg_addr_t'(`ATTN_M2 * `ATTN_M3);
            seg_m_c, seg_e_c:          return seg_addr_t'(1);   // one scalar per head.
            default:                   return seg_addr_t'(`ATTN_M3);
        endcase
    endfunction

endpackage

// File: common/host_pkg.sv
`include "attn_consts.svh"

package host_pkg;

    typedef enum logic {
        reg_ctrl   = 1'b0,
        reg_status = 1'b1
    } host_reg_t;

    typedef logic [`ATTN_CNT_W-1:0] head_cnt_t;

    localparam int HOST_SEL_BIT    = `ATTN_WB_ADR_W - 1;   // set for the registers.

    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_COUNT_LSB  = 1;
    localparam int CTRL_COUNT_MSB  = CTRL_COUNT_LSB + `ATTN_CNT_W - 1;

    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

// File: store/tensor_store.sv
`timescale 1ns/1ps
`include "attn_consts.svh"

module tensor_store (
    input  logic                    clk,
    input  logic                    we,
    input  logic [`ATTN_ADDR_W-1:0] waddr,
    input  logic [`ATTN_W-1:0]      wdata,
    input  logic                    rd_en,
    input  logic [`ATTN_ADDR_W-1:0] rd_addr,
    output logic [`ATTN_W-1:0]      rd_data
);

    localparam int DEPTH = 1 << `ATTN_ADDR_W;

    logic [`ATTN_W-1:0] mem [DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stream read port
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];   // data one cycle after rd_en.
        end
    end

endmodule

// File: host/wb_host_regs.sv
`timescale 1ns/1ps
`include "attn_consts.svh"

module wb_host_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`ATTN_WB_ADR_W-1:0] wb_adr,
    input  logic [`ATTN_W-1:0]        wb_dat_w,
    output logic [`ATTN_W-1:0]        wb_dat_r,
    output logic                      wb_ack,
    output logic                      st_we,
    output logic [`ATTN_ADDR_W-1:0]   st_waddr,
    output logic [`ATTN_W-1:0]        st_wdata,
    output logic                      start,
    output host_pkg::head_cnt_t       head_count,
    input  logic                      busy,
    input  logic                      done
);
    import host_pkg::*;

    logic      req;
    logic      reg_sel;
    host_reg_t reg_idx;

    assign req     = wb_cyc && wb_stb && !wb_ack;   // new cycle, not yet acked.
    assign reg_sel = wb_adr[HOST_SEL_BIT];
    assign reg_idx = host_reg_t'(wb_adr[0]);

    // store writes land on the same edge that raises ack.
    assign st_we    = req && wb_we && !reg_sel;
    assign st_waddr = wb_adr[`ATTN_ADDR_W-1:0];
    assign st_wdata = wb_dat_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            start      <= 1'b0;
            head_count <= '0;
        end else begin
            wb_ack <= req;
            start  <= 1'b0;
            if (req && wb_we && reg_sel && reg_idx == reg_ctrl) begin
                head_count <= wb_dat_w[CTRL_COUNT_MSB:CTRL_COUNT_LSB];
                start      <= wb_dat_w[CTRL_START_BIT];   // one cycle pulse.
            end
        end
    end

    // store words read back as zero.
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= '0;
            if (reg_sel && reg_idx == reg_status) begin
                wb_dat_r[STATUS_BUSY_BIT] <= busy;
                wb_dat_r[STATUS_DONE_BIT] <= done;
            end else if (reg_sel) begin
                wb_dat_r[CTRL_COUNT_MSB:CTRL_COUNT_LSB] <= head_count;
            end
        end
    end

    ack_needs_request: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

endmodule

// File: stream/segment_sequencer.sv
`timescale 1ns/1ps
`include "attn_consts.svh"

module segment_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [`ATTN_CNT_W-1:0]  head_count,
    input  logic                    seg_busy,
    input  logic                    seg_done,
    output logic                    seg_start,
    output logic [`ATTN_ADDR_W-1:0] seg_base,
    output seg_pkg::seg_t           seg_kind,
    output logic                    busy,
    output logic                    done
);
    import seg_pkg::*;

    localparam int KEEP_W = $clog2(`ATTN_KEEP_A + 1);
    localparam int CNT_W  = `ATTN_CNT_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } state_t;

    state_t            state;
    seg_t              cur;
    logic [CNT_W-1:0]  head;
    logic [CNT_W-1:0]  last_head;
    logic [KEEP_W-1:0] keep_cnt;    // head index within its input group.
    seg_addr_t         in_ptr;
    seg_addr_t         head_ptr;
    logic              count_ok;
    logic              keep_wrap;

    assign count_ok  = head_count != '0 && head_count <= CNT_W'(`ATTN_HEADS);
    assign keep_wrap = keep_cnt == KEEP_W'(`ATTN_KEEP_A - 1);

    assign seg_start = state == S_ISSUE;
    assign seg_kind  = cur;
    assign seg_base  = (cur == seg_i) ? in_ptr : head_ptr;
    assign busy      = state != S_IDLE;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // segment and head walk
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            done      <= 1'b0;
            cur       <= seg_i;
            head      <= '0;
            last_head <= '0;
            keep_cnt  <= '0;
            in_ptr    <= '0;
            head_ptr  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start && count_ok) begin
                        state     <= S_ISSUE;
                        done      <= 1'b0;
                        cur       <= seg_i;
                        head      <= '0;
                        last_head <= head_count - 1'b1;
                        keep_cnt  <= '0;
                        in_ptr    <= '0;
                        head_ptr  <= seg_addr_t'(`ATTN_HEAD_BASE);
                    end
                end
                S_ISSUE: begin
                    // segments are packed, so the next base follows this one.
                    state <= S_WAIT;
                    if (cur == seg_i) begin
                        in_ptr <= in_ptr + seg_len(cur);
                    end else begin
                        head_ptr <= head_ptr + seg_len(cur);
                    end
                end
                S_WAIT: begin
                    if (seg_done) begin
                        state <= S_ISSUE;
                        if (cur != seg_e_c) begin
                            cur <= seg_t'(cur + 1'b1);
                        end else if (head == last_head) begin
                            state <= S_IDLE;
                            done  <= 1'b1;
                        end else begin
                            head     <= head + 1'b1;
                            keep_cnt <= keep_wrap ? '0 : keep_cnt + 1'b1;
                            cur      <= keep_wrap ? seg_i : seg_w_q;   // new input group.
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    no_start_while_reading: assert property (@(posedge clk) disable iff (rst)
        seg_start |-> !seg_busy);

endmodule

// File: stream/stream_reader.sv
`timescale 1ns/1ps
`include "attn_consts.svh"

module stream_reader (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    seg_start,
    input  logic [`ATTN_ADDR_W-1:0] seg_base,
    input  seg_pkg::seg_t           seg_kind,
    output logic                    rd_en,
    output logic [`ATTN_ADDR_W-1:0] rd_addr,
    input  logic [`ATTN_W-1:0]      rd_data,
    output logic                    seg_busy,
    output logic                    seg_done,
    output logic                    m_valid,
    output logic [`ATTN_W-1:0]      m_data,
    output logic                    m_last,
    output seg_pkg::seg_t           m_seg,
    input  logic                    ready
);
    import seg_pkg::*;

    seg_addr_t          rd_left;     // reads still to issue.
    logic               rd_pend;     // word on its way back from the store.
    logic               pend_last;
    logic [`ATTN_W-1:0] buf_data [2];
    logic               buf_last [2];
    logic               wr_ptr;
    logic               rd_ptr;
    logic [1:0]         buf_cnt;
    logic               push;
    logic               pop;
    seg_t               kind;

    assign m_valid  = buf_cnt != 2'd0;
    assign m_data   = buf_data[rd_ptr];
    assign m_last   = buf_last[rd_ptr];
    assign m_seg    = kind;
    assign push     = rd_pend;
    assign pop      = m_valid && ready;
    assign seg_done = pop && m_last;

    // buffered plus in-flight words stay at two or fewer.
    assign rd_en = seg_busy && rd_left != '0 &&
                   ((buf_cnt + {1'b0, rd_pend}) < 2'd2 || pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            seg_busy <= 1'b0;
            rd_left  <= '0;
            rd_pend  <= 1'b0;
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            buf_cnt  <= 2'd0;
        end else begin
            rd_pend <= rd_en;
            if (seg_start) begin
                seg_busy <= 1'b1;
                rd_left  <= seg_len(seg_kind);
            end else if (rd_en) begin
                rd_left <= rd_left - 1'b1;
            end
            if (seg_done) begin
                seg_busy <= 1'b0;
            end
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            buf_cnt <= buf_cnt + {1'b0, push} - {1'b0, pop};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address, tag and buffer contents
    always_ff @(posedge clk) begin
        if (seg_start) begin
            rd_addr <= seg_base;
            kind    <= seg_kind;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
        if (rd_en) begin
            pend_last <= rd_left == seg_addr_t'(1);
        end
        if (push) begin
            buf_data[wr_ptr] <= rd_data;
            buf_last[wr_ptr] <= pend_last;
        end
    end

    hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
        m_valid && !ready |=>
            m_valid && $stable(m_data) && $stable(m_last) && $stable(m_seg));

endmodule

// File: verilog/attn_loader_top.sv
`timescale 1ns/1ps
`include "attn_consts.svh"

module attn_loader_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`ATTN_WB_ADR_W-1:0] wb_adr,
    input  logic [`ATTN_W-1:0]        wb_dat_w,
    output logic [`ATTN_W-1:0]        wb_dat_r,
    output logic                      wb_ack,
    output logic                      m_valid,
    output logic [`ATTN_W-1:0]        m_data,
    output logic                      m_last,
    output seg_pkg::seg_t             m_seg,
    input  logic                      ready
);
    import seg_pkg::*;
    import host_pkg::*;

    // host to store
    logic                    st_we;
    logic [`ATTN_ADDR_W-1:0] st_waddr;
    logic [`ATTN_W-1:0]      st_wdata;

    // store to reader
    logic                    rd_en;
    logic [`ATTN_ADDR_W-1:0] rd_addr;
    logic [`ATTN_W-1:0]      rd_data;

    // control and segment hand-off
    logic      start;
    head_cnt_t head_count;
    logic      busy;
    logic      done;
    logic      seg_start;
    seg_addr_t seg_base;
    seg_t      seg_kind;
    logic      seg_busy;
    logic      seg_done;

    wb_host_regs u_host (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .st_we      (st_we),
        .st_waddr   (st_waddr),
        .st_wdata   (st_wdata),
        .start      (start),
        .head_count (head_count),
        .busy       (busy),
        .done       (done)
    );

    tensor_store u_store (
        .clk     (clk),
        .we      (st_we),
        .waddr   (st_waddr),
        .wdata   (st_wdata),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    segment_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .head_count (head_count),
        .seg_busy   (seg_busy),
        .seg_done   (seg_done),
        .seg_start  (seg_start),
        .seg_base   (seg_base),
        .seg_kind   (seg_kind),
        .busy       (busy),
        .done       (done)
    );

    stream_reader u_reader (
        .clk       (clk),
        .rst       (rst),
        .seg_start (seg_start),
        .seg_base  (seg_base),
        .seg_kind  (seg_kind),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .seg_busy  (seg_busy),
        .seg_done  (seg_done),
        .m_valid   (m_valid),
        .m_data    (m_data),
        .m_last    (m_last),
        .m_seg     (m_seg),
        .ready     (ready)
    );

endmodule

// File: verif/tb_attn_loader.sv
`timescale 1ns/1ps
`include "attn_consts.svh"

module tb_attn_loader;
    import seg_pkg::*;
    import host_pkg::*;

    localparam int IMAGE_WORDS = `ATTN_HEAD_BASE + `ATTN_HEADS * `ATTN_HEAD_WORDS;
    localparam int RUN_WORDS   = 72;
    localparam int WATCH_NS    = (IMAGE_WORDS * 3 + 2 * RUN_WORDS * 8) * 20 * 2;
    localparam int ACK_WAIT    = 8;
    localparam int POLL_MAX    = 400;
    localparam logic [31:0] SEED = 32'h4882baca;

    logic                      clk;
    logic                      rst;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`ATTN_WB_ADR_W-1:0] wb_adr;
    logic [`ATTN_W-1:0]        wb_dat_w;
    logic [`ATTN_W-1:0]        wb_dat_r;
    logic                      wb_ack;
    logic                      m_valid;
    logic [`ATTN_W-1:0]        m_data;
    logic                      m_last;
    seg_t                      m_seg;
    logic                      ready = 1'b0;

    logic [31:0] image [IMAGE_WORDS];
    logic [31:0] exp_data [$];
    logic        exp_last [$];
    seg_t        exp_seg [$];
    logic [31:0] rng;
    logic        random_ready;
    int          value_errors;
    int          other_errors;
    int          rx_count;

    attn_loader_top DUT (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .m_valid  (m_valid),
        .m_data   (m_data),
        .m_last   (m_last),
        .m_seg    (m_seg),
        .ready    (ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            value_errors++;
            $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone master
    function automatic logic [7:0] reg_addr(input host_reg_t r);
        return 8'((1 << HOST_SEL_BIT) | int'(r));
    endfunction

    function automatic logic [31:0] ctrl_word(input int count);
        return 32'((count << CTRL_COUNT_LSB) | (1 << CTRL_START_BIT));
    endfunction

    task automatic wb_cycle(input logic write, input logic [7:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = write;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack && waited < ACK_WAIT) begin
            waited++;
            @(negedge clk);
        end
        if (!wb_ack) begin
            other_errors++;
            $display("no wishbone ack for address %h", adr);
        end
        check_value("ack delay", 32'(waited), 0);   // ack one cycle after request.
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, data, unused);
    endtask

    task automatic read_status(output logic busy_bit, output logic done_bit);
        logic [31:0] r;
        logic [31:0] spare;
        wb_cycle(1'b0, reg_addr(reg_status), '0, r);
        spare                  = r;
        spare[STATUS_BUSY_BIT] = 1'b0;
        spare[STATUS_DONE_BIT] = 1'b0;
        check_value("status spare bits", spare, 0);
        busy_bit = r[STATUS_BUSY_BIT];
        done_bit = r[STATUS_DONE_BIT];
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stream predictor
    function automatic int words_in(input seg_t s);
        if (s == seg_i) return `ATTN_M1 * `ATTN_M2;
        if (s == seg_w_q || s == seg_w_k || s == seg_w_v) return `ATTN_M2 * `ATTN_M3;
        if (s == seg_m_c || s == seg_e_c) return 1;
        return `ATTN_M3;   // bias, m and e.
    endfunction

    task automatic queue_segment(input seg_t s, input int base);
        int n;
        n = words_in(s);
        for (int i = 0; i < n; i++) begin
            exp_data.push_back(image[base + i]);
            exp_last.push_back(i == n - 1);
            exp_seg.push_back(s);
        end
    endtask

    task automatic build_expected(input int heads);
        int base;
        for (int h = 0; h < heads; h++) begin
            if (h % `ATTN_KEEP_A == 0) begin
                queue_segment(seg_i, (h / `ATTN_KEEP_A) * `ATTN_M1 * `ATTN_M2);
            end
            base = `ATTN_HEAD_BASE + h * `ATTN_HEAD_WORDS;
            for (int k = int'(seg_w_q); k <= int'(seg_e_c); k++) begin
                queue_segment(seg_t'(k), base);
                base += words_in(seg_t'(k));
            end
        end
    endtask

    // ready changes on the falling edge, so a word seen here transfers on the next rise.
    always @(negedge clk) begin : watch_stream
        logic [31:0] want_data;
        logic        want_last;
        seg_t        want_seg;
        if (random_ready) begin
            rng   = next_random(rng);
            ready = rng[7];
        end else begin
            ready = 1'b1;
        end
        if (m_valid && ready) begin
            rx_count++;
            if (exp_data.size() == 0) begin
                other_errors++;
                $display("stream word %h arrived with nothing left to expect", m_data);
            end else begin
                want_data = exp_data.pop_front();
                want_last = exp_last.pop_front();
                want_seg  = exp_seg.pop_front();
                check_value("m_data", m_data, want_data);
                check_value("m_last", 32'(m_last), 32'(want_last));
                check_value("m_seg", 32'(m_seg), 32'(want_seg));
            end
        end
    end

    task automatic run_heads(input int heads, input int words);
        logic b;
        logic d;
        int   polls;
        rx_count = 0;
        build_expected(heads);
        wb_write(reg_addr(reg_ctrl), ctrl_word(heads));
        polls = 0;
        read_status(b, d);
        while (!(d && !b) && polls < POLL_MAX) begin
            polls++;
            read_status(b, d);
        end
        if (!(d && !b)) begin
            other_errors++;
            $display("run of %0d heads never reported done", heads);
        end
        check_value("words streamed", 32'(rx_count), 32'(words));
        check_value("words left over", 32'(exp_data.size()), 0);
        check_value("status busy", 32'(b), 0);
        check_value("status done", 32'(d), 1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    initial begin
        logic        b;
        logic        d;
        logic [31:0] r;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        random_ready = 1'b0;
        rng          = SEED;
        value_errors = 0;
        other_errors = 0;
        rx_count     = 0;
        $readmemh("verif/attn_loader_stim.hex", image);
        if ($isunknown(image[IMAGE_WORDS-1])) begin
            other_errors++;
            $display("memory image file is missing or too short");
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_value("m_valid after reset", 32'(m_valid), 0);
        read_status(b, d);
        check_value("busy after reset", 32'(b), 0);
        check_value("done after reset", 32'(d), 0);

        for (int a = 0; a < IMAGE_WORDS; a++) begin
            wb_write(8'(a), image[a]);
        end

        // the store is write only from the host.
        wb_cycle(1'b0, 8'(5), '0, r);
        check_value("store readback", r, 0);

        run_heads(2, IMAGE_WORDS);   // ready held high.
        @(posedge clk);
        random_ready = 1'b1;
        run_heads(2, IMAGE_WORDS);
        @(posedge clk);
        random_ready = 1'b0;

        // count 0 must be ignored.
        rx_count = 0;
        wb_write(reg_addr(reg_ctrl), ctrl_word(0));
        repeat (16) @(negedge clk);
        check_value("words for count 0", 32'(rx_count), 0);
        read_status(b, d);
        check_value("busy after count 0", 32'(b), 0);
        check_value("done after count 0", 32'(d), 1);

        run_heads(1, `ATTN_M1 * `ATTN_M2 + `ATTN_HEAD_WORDS);

        $display("errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors + other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCH_NS);
        $display("timeout: the run did not finish within %0d ns", WATCH_NS);
        $display("errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors + 1);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verif/attn_loader_stim.hex
// one 32-bit store word per line from address 0: input block, head 0 block, head 1 block
// word layout: head tag, segment index, marker, store address
00d1f000
00d1f001
00d1f002
00d1f003
119e3704
119e3705
119e3706
119e3707
129e3708
129e3709
139e370a
139e370b
149e370c
149e370d
159e370e
159e370f
159e3710
159e3711
169e3712
169e3713
179e3714
179e3715
189e3716
189e3717
199e3718
199e3719
199e371a
199e371b
1a9e371c
1a9e371d
1b9e371e
1b9e371f
1c9e3720
1c9e3721
1d9e3722
1e9e3723
2179b924
2179b925
2179b926
2179b927
2279b928
2279b929
2379b92a
2379b92b
2479b92c
2479b92d
2579b92e
2579b92f
2579b930
2579b931
2679b932
2679b933
2779b934
2779b935
2879b936
2879b937
2979b938
2979b939
2979b93a
2979b93b
2a79b93c
2a79b93d
2b79b93e
2b79b93f
2c79b940
2c79b941
2d79b942
2e79b943

// File: list.f
+incdir+common
common/seg_pkg.sv
common/host_pkg.sv
store/tensor_store.sv
host/wb_host_regs.sv
stream/segment_sequencer.sv
stream/stream_reader.sv
verilog/attn_loader_top.sv
verif/tb_attn_loader.sv

// File: run.sh
#!/bin/sh
# build and run the attention loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_attn_loader -o sim_attn_loader

out=$(./obj_dir/sim_attn_loader)
echo "$out"

# non-zero exit when the pass line is absent
echo "$out" | grep -q "All tests passed!"
